// File: build.f
source/dct_pkg.sv
source/dct_ctrl.sv
source/dct_butterfly.sv
source/dct_even.sv
source/dct_odd.sv
source/dct_out_pack.sv
source/dct_row_16.sv
tests/tb_dct_row_chk.sv
tests/tb_dct_row.sv

// File: Makefile
# Verilator simulation of the 16-point DCT row transform

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_dct_row
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
PASS_MSG  := Simulation finished: PASS

SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

$(OBJDIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# The run passes only if the pass line shows up in the output
test: $(OBJDIR)/V$(TOP)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// File: tests/tb_dct_row.sv
// Testbench for dct_row_16 with directed table rows, LFSR rows, weight-rule model and checks
`timescale 1ns/1ps

module tb_dct_row;

    typedef dct_pkg::sample_t [dct_pkg::n_points-1:0] xrow_t;
    typedef dct_pkg::coef_t   [dct_pkg::n_points-1:0] krow_t;

    localparam int n_table    = 8;
    localparam int n_random   = 20;
    localparam int rst_cycles = 8;

    // Directed rows with sample 0 in the top byte
    localparam logic [127:0] row_tab [n_table] = '{
        128'h0,
        {16{8'hff}},
        128'hff00_0000_0000_0000_0000_0000_0000_0000,
        128'h0000_0000_0000_0000_0000_0000_0000_00ff,
        {8{16'h00ff}},
        128'h0011_2233_4455_6677_8899_aabb_ccdd_eeff,
        128'hffff_ffff_ffff_ffff_0000_0000_0000_0000,
        128'hf0e0_d0c0_b0a0_9080_7060_5040_3020_1000
    };

    // Idle cycles after each directed row
    // The first four rows go back to back
    localparam int gap_tab [n_table] = '{0, 0, 0, 2, 3, 0, 5, 1};

    logic  clk;
    logic  rst_n;
    logic  in_valid;
    xrow_t x_n_in;
    logic  out_valid;
    krow_t x_k_out;

    // Expected rows and the cycle each row entered
    krow_t exp_q [$];
    int    issue_q [$];
    krow_t last_row;
    bit    seen_out = 1'b0;

    int cycle        = 0;
    int limit        = 0;
    int mismatch_cnt = 0;
    int proto_cnt    = 0;

    logic [31:0] lfsr_state;

    dct_row_16 i_dct_row_16 (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .x_n_in   (x_n_in),
        .out_valid(out_valid),
        .x_k_out  (x_k_out)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic next_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            b[i]       = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Signed weight of sample n in output k
    // Angle index in units of pi/32
    function automatic int rule_weight(input int k, input int n);
        int m;
        int sgn;
        if (k == 0) begin
            return 32;
        end
        m   = ((2 * n + 1) * k) % 64;
        sgn = 1;
        if (m > 32) begin
            m = 64 - m;
        end
        if (m > 16) begin
            m   = 32 - m;
            sgn = -1;
        end
        return sgn * dct_pkg::cos_tab[m];
    endfunction

    // Direct 16x16 sum reduced to bits 16..6
    function automatic krow_t model_row(input xrow_t row);
        krow_t       res;
        int          acc;
        logic [31:0] acc_bits;
        for (int k = 0; k < 16; k++) begin
            acc = 0;
            for (int n = 0; n < 16; n++) begin
                acc += int'(row[15-n]) * rule_weight(k, n);
            end
            acc_bits   = acc;
            res[15-k]  = acc_bits[16:6];
        end
        return res;
    endfunction

    // Sparse gaps among the LFSR rows
    function automatic int random_gap(input int i);
        return (i % 4 == 3) ? 1 : 0;
    endfunction

    // Reset cycles plus one cycle per row plus all gaps and a margin
    function automatic int run_limit();
        int total;
        total = rst_cycles + n_table + n_random + 32;
        for (int i = 0; i < n_table; i++) begin
            total += gap_tab[i];
        end
        for (int i = 0; i < n_random; i++) begin
            total += random_gap(i);
        end
        return total;
    endfunction

    task automatic compare_val(input int got, input int exp, input string what);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_row(input krow_t got, input krow_t exp, input string what);
        for (int k = 0; k < 16; k++) begin
            compare_val(int'(got[15-k]), int'(exp[15-k]), $sformatf("%s X[%0d]", what, k));
        end
    endtask

    // One valid cycle followed by gap idle cycles with junk on the data bus
    task automatic apply_row(input xrow_t row, input int gap);
        @(posedge clk);
        in_valid <= 1'b1;
        x_n_in   <= row;
        exp_q.push_back(model_row(row));
        for (int g = 0; g < gap; g++) begin
            @(posedge clk);
            in_valid <= 1'b0;
            x_n_in   <= ~row;
        end
    endtask

    task automatic finish_run(input bit timed_out);
        int assert_cnt;
        assert_cnt = i_dct_row_16.i_chk.assert_fails;
        if (exp_q.size() != 0) begin
            proto_cnt += exp_q.size();
            $display("ERROR: %0d rows never produced out_valid", exp_q.size());
        end
        $display("Errors: %0d mismatches, %0d strobe errors, %0d assertion failures, timeout %0d",
                 mismatch_cnt, proto_cnt, assert_cnt, timed_out);
        if (!timed_out && mismatch_cnt == 0 && proto_cnt == 0 && assert_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    // Cycle count and run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (limit > 0 && cycle >= limit) begin
            $display("ERROR: run did not complete within %0d cycles", limit);
            finish_run(1'b1);
        end
    end

    // Outputs sampled on the falling edge away from the register updates
    always @(negedge clk) begin : monitor
        int t0;
        if (rst_n === 1'b1) begin
            if (in_valid) begin
                issue_q.push_back(cycle);
            end
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    proto_cnt++;
                    $display("ERROR at %0t ns: out_valid with no row in flight", $time);
                end else begin
                    t0 = issue_q.pop_front();
                    if (cycle - t0 != 3) begin
                        proto_cnt++;
                        $display("ERROR at %0t ns: result came %0d cycles after its row",
                                 $time, cycle - t0);
                    end
                    check_row(x_k_out, exp_q.pop_front(), "row");
                end
                last_row = x_k_out;
                seen_out = 1'b1;
            end else if (seen_out) begin
                check_row(x_k_out, last_row, "hold");
            end else begin
                check_row(x_k_out, '0, "after reset");
            end
        end
    end

    initial begin : stimulus
        xrow_t      row;
        logic [7:0] b;
        // Strobe and a full row early in reset must not reach the pipeline
        rst_n      = 1'b0;
        in_valid   = 1'b1;
        x_n_in     = {16{8'hff}};
        lfsr_state = 32'h7708;
        limit      = run_limit();
        repeat (rst_cycles - 3) @(posedge clk);
        // Strobe low for the last three reset cycles
        in_valid <= 1'b0;
        x_n_in   <= '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < n_table; i++) begin
            apply_row(row_tab[i], gap_tab[i]);
        end
        for (int i = 0; i < n_random; i++) begin
            for (int n = 0; n < 16; n++) begin
                next_byte(b);
                row[15-n] = b;
            end
            apply_row(row, random_gap(i));
        end
        @(posedge clk);
        in_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        // A few idle cycles to catch stray strobes
        repeat (4) @(posedge clk);
        finish_run(1'b0);
    end

endmodule

// File: tests/tb_dct_row_chk.sv
// Bound assertions on dct_row_16: strobe in reset, three-cycle latency, output hold
`timescale 1ns/1ps

module tb_dct_row_chk (
    input logic                                          clk,
    input logic                                          rst_n,
    input logic                                          in_valid,
    input logic                                          out_valid,
    input logic [dct_pkg::n_points*dct_pkg::coef_w-1:0]  x_k_out
);

    // Count of failed assertions
    int assert_fails = 0;

    // Synchronous reset clears the strobe at the next edge
    reset_quiet: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else begin
            $error("out_valid high after a reset cycle");
            assert_fails++;
        end

    // Strobe is the input strobe three edges later
    latency_three: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid, 3))
        else begin
            $error("out_valid does not follow in_valid by three cycles");
            assert_fails++;
        end

    // Output register only loads together with a strobe
    hold_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> $stable(x_k_out))
        else begin
            $error("x_k_out changed while out_valid was low");
            assert_fails++;
        end

endmodule

bind dct_row_16 tb_dct_row_chk i_chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .out_valid(out_valid),
    .x_k_out  (x_k_out)
);

// File: source/dct_row_16.sv
// Top level of the 16-point DCT row transform: control and three-stage datapath
`timescale 1ns/1ps

module dct_row_16 (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     in_valid,
    input  dct_pkg::sample_t [dct_pkg::n_points-1:0] x_n_in,
    output logic                                     out_valid,
    output dct_pkg::coef_t   [dct_pkg::n_points-1:0] x_k_out
);

    // Stage enables
    logic en_s1;
    logic en_s2;
    logic en_s3;

    // Stage 1 to stage 2
    dct_pkg::bf1_t [dct_pkg::n_points/2-1:0] bf_sum;
    dct_pkg::bf1_t [dct_pkg::n_points/2-1:0] bf_diff;

    // Stage 2 to stage 3
    dct_pkg::acc_t [dct_pkg::n_points/2-1:0] even_acc;
    dct_pkg::acc_t [dct_pkg::n_points/2-1:0] odd_acc;

    dct_ctrl i_dct_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .en_s1    (en_s1),
        .en_s2    (en_s2),
        .en_s3    (en_s3),
        .out_valid(out_valid)
    );

    dct_butterfly i_dct_butterfly (.clk(clk), .rst_n(rst_n), .en_s1(en_s1),
        .x_n_in(x_n_in), .bf_sum(bf_sum), .bf_diff(bf_diff));

    // Even and odd halves run side by side
    dct_even i_dct_even (.clk(clk), .rst_n(rst_n), .en_s2(en_s2),
        .bf_sum(bf_sum), .even_acc(even_acc));

    dct_odd i_dct_odd (.clk(clk), .rst_n(rst_n), .en_s2(en_s2),
        .bf_diff(bf_diff), .odd_acc(odd_acc));

    dct_out_pack i_dct_out_pack (.clk(clk), .rst_n(rst_n), .en_s3(en_s3),
        .even_acc(even_acc), .odd_acc(odd_acc), .x_k_out(x_k_out));

endmodule

// File: source/dct_out_pack.sv
// Interleave even and odd sums, keep bits 16..6, register the packed row on en_s3
`timescale 1ns/1ps

module dct_out_pack (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    en_s3,
    input  dct_pkg::acc_t [dct_pkg::n_points/2-1:0] even_acc,
    input  dct_pkg::acc_t [dct_pkg::n_points/2-1:0] odd_acc,
    output dct_pkg::coef_t [dct_pkg::n_points-1:0]  x_k_out
);

    // Truncated row, same field order as x_k_out
    dct_pkg::coef_t [dct_pkg::n_points-1:0] pack_d;

    // X[k] lands in field n_points-1-k, X[0] on top
    always_comb begin : interleave
        dct_pkg::acc_t sel;
        for (int k = 0; k < dct_pkg::n_points; k++) begin
            if (k % 2 == 0) begin
                sel = even_acc[k/2];
            end else begin
                sel = odd_acc[k/2];
            end
            // Drop 6 fraction bits, upper bits wrap away
            pack_d[dct_pkg::n_points-1-k] = sel[dct_pkg::trunc_msb:dct_pkg::trunc_lsb];
        end
    end

    // Output register holds the last row between strobes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            x_k_out <= '0;
        end else if (en_s3) begin
            x_k_out <= pack_d;
        end
    end

endmodule

// File: source/dct_odd.sv
// Odd coefficients: constant matrix on the stage-1 differences, registered on en_s2
`timescale 1ns/1ps

module dct_odd (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    en_s2,
    input  dct_pkg::bf1_t [dct_pkg::n_points/2-1:0] bf_diff,
    output dct_pkg::acc_t [dct_pkg::n_points/2-1:0] odd_acc
);

    // Stage-1 differences as signed locals
    dct_pkg::bf1_t d [dct_pkg::n_points/2];

    // Full sums, entry j holds X[2j+1]
    dct_pkg::acc_t odd_d [dct_pkg::n_points/2];

    // Odd k is antisymmetric about the row centre
    // so x[i]-x[15-i] carries everything, 8 taps per output
    always_comb begin
        for (int i = 0; i < dct_pkg::n_points / 2; i++) begin
            d[i] = bf_diff[i];
        end
        for (int j = 0; j < dct_pkg::n_points / 2; j++) begin
            odd_d[j] = '0;
            for (int i = 0; i < dct_pkg::n_points / 2; i++) begin
                // Weights fold to cos_tab entries 1, 3, .., 15 with signs
                odd_d[j] += dct_pkg::acc_t'(d[i])
                          * dct_pkg::acc_t'(dct_pkg::cos_weight(2 * j + 1, i));
            end
        end
    end

    // Stage 2 register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            odd_acc <= '0;
        end else if (en_s2) begin
            for (int j = 0; j < dct_pkg::n_points / 2; j++) begin
                odd_acc[j] <= odd_d[j];
            end
        end
    end

endmodule

// File: source/dct_even.sv
// Even coefficients: second and third butterflies plus rotations, registered on en_s2
`timescale 1ns/1ps

module dct_even (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    en_s2,
    input  dct_pkg::bf1_t [dct_pkg::n_points/2-1:0] bf_sum,
    output dct_pkg::acc_t [dct_pkg::n_points/2-1:0] even_acc
);

    // Stage-1 sums as signed locals
    dct_pkg::bf1_t s [dct_pkg::n_points/2];

    // Second butterfly, one bit of growth
    logic signed [dct_pkg::bf1_w:0] ee [dct_pkg::n_points/4];
    logic signed [dct_pkg::bf1_w:0] eo [dct_pkg::n_points/4];

    // Third butterfly on the even-even half
    logic signed [dct_pkg::bf1_w+1:0] eee [dct_pkg::n_points/8];
    logic signed [dct_pkg::bf1_w+1:0] eeo [dct_pkg::n_points/8];

    // Full sums, entry j holds X[2j]
    dct_pkg::acc_t even_d [dct_pkg::n_points/2];

    // Butterfly network
    always_comb begin
        for (int i = 0; i < dct_pkg::n_points / 2; i++) begin
            s[i] = bf_sum[i];
        end
        // Pairs i and 7-i
        for (int i = 0; i < dct_pkg::n_points / 4; i++) begin
            ee[i] = s[i] + s[dct_pkg::n_points/2-1-i];
            eo[i] = s[i] - s[dct_pkg::n_points/2-1-i];
        end
        // Pairs i and 3-i
        for (int i = 0; i < dct_pkg::n_points / 8; i++) begin
            eee[i] = ee[i] + ee[dct_pkg::n_points/4-1-i];
            eeo[i] = ee[i] - ee[dct_pkg::n_points/4-1-i];
        end
    end

    // Constant products, weight taken at sample index i of each reduced vector
    // k mod 8 = 0: X[0], X[8] from eee
    // k mod 8 = 4: X[4], X[12] from eeo
    // k mod 4 = 2: X[2], X[6], X[10], X[14] from eo, weights 44 38 25 9 for X[2]
    always_comb begin
        for (int j = 0; j < dct_pkg::n_points / 2; j++) begin
            even_d[j] = '0;
            if ((2 * j) % 8 == 0) begin
                for (int i = 0; i < dct_pkg::n_points / 8; i++) begin
                    even_d[j] += dct_pkg::acc_t'(eee[i])
                               * dct_pkg::acc_t'(dct_pkg::cos_weight(2 * j, i));
                end
            end else if ((2 * j) % 8 == 4) begin
                for (int i = 0; i < dct_pkg::n_points / 8; i++) begin
                    even_d[j] += dct_pkg::acc_t'(eeo[i])
                               * dct_pkg::acc_t'(dct_pkg::cos_weight(2 * j, i));
                end
            end else begin
                // Four-point rotation
                for (int i = 0; i < dct_pkg::n_points / 4; i++) begin
                    even_d[j] += dct_pkg::acc_t'(eo[i])
                               * dct_pkg::acc_t'(dct_pkg::cos_weight(2 * j, i));
                end
            end
        end
    end

    // Stage 2 register, parallel with the odd part
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            even_acc <= '0;
        end else if (en_s2) begin
            for (int j = 0; j < dct_pkg::n_points / 2; j++) begin
                even_acc[j] <= even_d[j];
            end
        end
    end

endmodule

// File: source/dct_butterfly.sv
// First butterfly stage: mirrored pair sums and differences, registered on en_s1
`timescale 1ns/1ps

module dct_butterfly (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     en_s1,
    input  dct_pkg::sample_t [dct_pkg::n_points-1:0] x_n_in,
    output dct_pkg::bf1_t  [dct_pkg::n_points/2-1:0] bf_sum,
    output dct_pkg::bf1_t  [dct_pkg::n_points/2-1:0] bf_diff
);

    // Combinational pair results
    dct_pkg::bf1_t sum_d  [dct_pkg::n_points/2];
    dct_pkg::bf1_t diff_d [dct_pkg::n_points/2];

    // Sample i sits in field n_points-1-i, sample 0 in the top byte
    // So the mirror sample 15-i sits in field i
    always_comb begin
        for (int i = 0; i < dct_pkg::n_points / 2; i++) begin
            // Zero extension before the signed add
            sum_d[i]  = dct_pkg::bf1_t'(x_n_in[dct_pkg::n_points-1-i])
                      + dct_pkg::bf1_t'(x_n_in[i]);
            diff_d[i] = dct_pkg::bf1_t'(x_n_in[dct_pkg::n_points-1-i])
                      - dct_pkg::bf1_t'(x_n_in[i]);
        end
    end

    // Stage 1 register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bf_sum  <= '0;
            bf_diff <= '0;
        end else if (en_s1) begin
            for (int i = 0; i < dct_pkg::n_points / 2; i++) begin
                bf_sum[i]  <= sum_d[i];
                bf_diff[i] <= diff_d[i];
            end
        end
    end

endmodule

// File: source/dct_ctrl.sv
// Valid shift register producing the three stage enables and the output strobe
`timescale 1ns/1ps

module dct_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    output logic en_s1,
    output logic en_s2,
    output logic en_s3,
    output logic out_valid
);

    // Bit 0 follows the butterfly register, bit 2 follows the output register
    logic [2:0] valid_sr;

    // One row may enter per cycle, so every tap is a plain delay
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[1:0], in_valid};
        end
    end

    // Butterfly loads in the same cycle the row is presented
    assign en_s1 = in_valid;

    // Even and odd sums load one cycle later
    assign en_s2 = valid_sr[0];

    // Truncated row loads two cycles later
    assign en_s3 = valid_sr[1];

    // Strobe lines up with the registered output row
    assign out_valid = valid_sr[2];

endmodule

// File: source/dct_pkg.sv
// Widths, scalar types, cosine weight table, output slice range and weight function
package dct_pkg;

    // Row geometry
    localparam int n_points = 16;

    // Input samples are unsigned bytes
    localparam int sample_w = 8;

    // Output coefficients are signed
    localparam int coef_w = 11;

    // Stage-1 sums reach 510 and differences reach -255, both signed
    localparam int bf1_w = sample_w + 2;

    // Full-precision sum, worst case 16 * 255 * 45 in magnitude
    localparam int acc_w = 20;

    // Kept bits of a full sum: exact sum >> 6, wrapped to coef_w bits
    localparam int trunc_lsb = 6;
    localparam int trunc_msb = 16;

    // Cosine weights, entry m ~ 45.25 * cos(m * pi / 32)
    // Entry 0 is the DC weight, entry 16 is the zero crossing
    localparam int cos_tab [0:16] = '{
        32, 45, 44, 43, 42, 40, 38, 35,
        32, 29, 25, 21, 17, 13,  9,  4,
        0
    };

    // Scalar payload types
    typedef logic        [sample_w-1:0] sample_t;
    typedef logic signed [bf1_w-1:0]    bf1_t;
    typedef logic signed [acc_w-1:0]    acc_t;
    typedef logic signed [coef_w-1:0]   coef_t;

    // Signed weight of sample n in output k
    // m = (2n+1)k mod 64, angle in units of pi/32
    // m > 32 folds to 64-m, cosine is even so the sign stays
    // m > 16 folds to 32-m with the sign negated
    // k = 0 always lands on m = 0, the DC weight of 32
    // Output k is bits 16..6 of sum over n of x[n] * weight
    function automatic int cos_weight(input int k, input int n);
        int m;
        int sgn;
        m   = ((2 * n + 1) * k) % (4 * n_points);
        sgn = 1;
        if (m > 2 * n_points) begin
            m = 4 * n_points - m;
        end
        if (m > n_points) begin
            m   = 2 * n_points - m;
            sgn = -sgn;
        end
        return sgn * cos_tab[m];
    endfunction

endpackage
